// ==== bench/complexIntegerUnitTb.sv ====
/*
 * Testbench for the complex integer unit. Dispatches random MUL, DIV and
 * REM ops, applies range and flush-all recoveries, and scores every lane
 * result against a reference model indexed by op id.
 */
`timescale 1ns/1ps

module complexIntegerUnitTb;
    import complexOpPkg::*;
    import pipelinePkg::*;

    localparam int opCount = 64;

    logic clock;
    logic reset;
    logic dispatchValid;
    ComplexOpEntry dispatchOp;
    logic queueFull;
    FlushRange recovery;
    ComplexResult result [issueWidth];

    // Scoreboard with one slot per op id
    logic [dataWidth-1:0] expectedValue [opCount];
    bit pending [opCount];
    bit maybeFlushed [opCount];
    int seed = 66304;
    int nextId = 0;
    int opsSent = 0;
    int cycleCount = 0;
    bit sawFull = 1'b0;
    string testName = "reset";

    complexIntegerUnit u_complexIntegerUnit (
        .clock, .reset, .dispatchValid, .dispatchOp, .queueFull, .recovery, .result
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic failRun();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic reportFailure(string what);
        $display("%s", what);
        failRun();
    endtask

    task automatic checkValue(string name, logic [dataWidth-1:0] expected,
                              logic [dataWidth-1:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected 0x%h actual 0x%h", name, expected, actual);
            failRun();
        end
    endtask

    // Reference model of the three opcodes
    function automatic logic [dataWidth-1:0] expectedResult(ComplexOpcode code,
            logic [dataWidth-1:0] a, logic [dataWidth-1:0] b);
        logic [2*dataWidth-1:0] product;
        product = 32'(a) * 32'(b);
        case (code)
            OP_MUL:  return product[dataWidth-1:0];
            OP_DIV:  return (b == 0) ? '1 : a / b;
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    // Circular distance from head decides membership
    function automatic bit rangeHit(FlushRange r, ActiveListPtr ptr);
        ActiveListPtr offset;
        ActiveListPtr span;
        offset = ptr - r.headPtr;
        span = r.tailPtr - r.headPtr;
        return r.toRecovery && (r.flushAll || offset < span);
    endfunction

    function automatic int countOutstanding();
        int count;
        count = 0;
        for (int id = 0; id < opCount; id++) begin
            if (pending[id] && !maybeFlushed[id]) begin
                count++;
            end
        end
        return count;
    endfunction

    task automatic sendOp(ComplexOpcode code, logic [dataWidth-1:0] a,
                          logic [dataWidth-1:0] b);
        ComplexOpEntry op;
        if (nextId >= opCount) begin
            reportFailure("Ran out of unique op ids");
        end
        op.opcode = code;
        op.srcA = a;
        op.srcB = b;
        op.activeListPtr = ActiveListPtr'(nextId % 16);
        op.opId = opIdWidth'(nextId);
        // Queue state is settled at the falling edge
        @(negedge clock);
        while (queueFull) begin
            sawFull = 1'b1;
            @(negedge clock);
        end
        @(posedge clock);
        expectedValue[nextId] = expectedResult(code, a, b);
        pending[nextId] = 1'b1;
        maybeFlushed[nextId] = 1'b0;
        dispatchValid <= 1'b1;
        dispatchOp <= op;
        nextId++;
        opsSent++;
        @(posedge clock);
        dispatchValid <= 1'b0;
    endtask

    task automatic applyRecovery(bit all, ActiveListPtr head, ActiveListPtr tail);
        FlushRange r;
        r.toRecovery = 1'b1;
        r.flushAll = all;
        r.headPtr = head;
        r.tailPtr = tail;
        @(posedge clock);
        recovery <= r;
        for (int id = 0; id < opCount; id++) begin
            if (pending[id] && rangeHit(r, ActiveListPtr'(id % 16))) begin
                maybeFlushed[id] = 1'b1;
            end
        end
        @(posedge clock);
        recovery <= '0;
    endtask

    task automatic waitDrain();
        @(posedge clock);
        while (countOutstanding() != 0) begin
            @(posedge clock);
        end
    endtask

    // Scoreboard compare on both lanes
    always @(negedge clock) begin
        int id;
        if (!reset) begin
            for (int i = 0; i < issueWidth; i++) begin
                if (result[i].valid) begin
                    id = result[i].opId;
                    if (!pending[id]) begin
                        reportFailure($sformatf("Lane %0d returned opId %0d which is not pending",
                                                i, id));
                    end
                    checkValue($sformatf("%s opId %0d", testName, id), expectedValue[id],
                               result[i].value);
                    pending[id] = 1'b0;
                end
            end
        end
    end

    always @(negedge clock) begin
        cycleCount++;
        if (cycleCount > 40 * opsSent + 200) begin
            reportFailure($sformatf("Timeout after %0d cycles with %0d ops sent",
                                    cycleCount, opsSent));
        end
    end

    initial begin
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        int leftover;
        int settleCycles;
        reset = 1'b1;
        dispatchValid = 1'b0;
        dispatchOp = '0;
        recovery = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        testName = "mulRandom";
        for (int k = 0; k < 10; k++) begin
            sendOp(OP_MUL, 16'($random(seed)), 16'($random(seed)));
        end
        waitDrain();

        // Every third divisor is zero and the rest are small
        testName = "divRem";
        for (int k = 0; k < 14; k++) begin
            a = 16'($random(seed));
            b = (k % 3 == 0) ? 16'h0000 : 16'($random(seed)) & 16'h00ff;
            sendOp((k % 2 == 1) ? OP_REM : OP_DIV, a, b);
        end
        waitDrain();

        testName = "mixFull";
        sawFull = 1'b0;
        for (int k = 0; k < 16; k++) begin
            sendOp((k % 2 == 1) ? OP_DIV : OP_MUL, 16'($random(seed)), 16'($random(seed)));
        end
        waitDrain();
        checkValue("mixFull queueFull seen", 16'd1, 16'(sawFull));

        testName = "rangeFlush";
        for (int k = 0; k < 6; k++) begin
            sendOp((k % 2 == 1) ? OP_REM : OP_DIV, 16'($random(seed)), 16'($random(seed)));
        end
        applyRecovery(1'b0, 4'd11, 4'd13);
        waitDrain();
        // Wrapped range across the pointer rollover
        for (int k = 0; k < 6; k++) begin
            sendOp((k % 2 == 1) ? OP_DIV : OP_REM, 16'($random(seed)), 16'($random(seed)));
        end
        applyRecovery(1'b0, 4'd15, 4'd1);
        waitDrain();

        testName = "flushAll";
        for (int k = 0; k < 4; k++) begin
            sendOp(OP_DIV, 16'($random(seed)), 16'($random(seed)));
        end
        applyRecovery(1'b1, 4'd0, 4'd0);
        for (int k = 0; k < 8; k++) begin
            sendOp(ComplexOpcode'(k % 3), 16'($random(seed)), 16'($random(seed)));
        end

        // Wait for the fresh ops, bounded by their worst-case latency
        settleCycles = 0;
        while (countOutstanding() != 0 && settleCycles < 40 * 8) begin
            @(posedge clock);
            settleCycles++;
        end
        // Let any surviving in-range ops finish
        repeat (40) @(posedge clock);
        leftover = countOutstanding();
        if (leftover != 0) begin
            reportFailure($sformatf("%0d ops outside any flush range never completed",
                                    leftover));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== hdl/complexExecLane.sv ====
/*
 * One complex execution lane. MUL finishes in the cycle after the op is
 * registered; DIV and REM hold the lane busy until the shared divider
 * returns, then pick quotient or remainder.
 */
`timescale 1ns/1ps

module complexExecLane (
    input  logic                             clock,
    input  logic                             reset,
    input  pipelinePkg::ExecStageReg         execIn,
    output logic                             divRequest,
    input  logic                             divGrant,
    input  logic                             divDone,
    input  logic [complexOpPkg::dataWidth-1:0] quotient,
    input  logic [complexOpPkg::dataWidth-1:0] remainder,
    output logic                             busy,
    output complexOpPkg::ComplexResult       result
);
    import complexOpPkg::*;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_MUL,
        LANE_DIV_REQ,
        LANE_DIV_WAIT
    } LaneState;

    LaneState state;
    ComplexOpEntry opReg;
    logic [2*dataWidth-1:0] product;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= LANE_IDLE;
        end else if (execIn.valid) begin
            state <= (execIn.op.opcode == OP_MUL) ? LANE_MUL : LANE_DIV_REQ;
        end else begin
            case (state)
                LANE_MUL:      state <= LANE_IDLE;
                LANE_DIV_REQ:  state <= divGrant ? LANE_DIV_WAIT : LANE_DIV_REQ;
                LANE_DIV_WAIT: state <= divDone ? LANE_IDLE : LANE_DIV_WAIT;
                default:       state <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (execIn.valid) begin
            opReg <= execIn.op;
        end
    end

    assign product = opReg.srcA * opReg.srcB;

    always_comb begin
        divRequest = (state == LANE_DIV_REQ);
        // Drops in the result cycle so the next op can issue at once
        busy = (state == LANE_DIV_REQ) || (state == LANE_DIV_WAIT && !divDone);

        result.valid = (state == LANE_MUL) || (state == LANE_DIV_WAIT && divDone);
        result.opId = opReg.opId;
        if (opReg.opcode == OP_MUL) begin
            result.value = product[dataWidth-1:0];
        end else begin
            result.value = (opReg.opcode == OP_DIV) ? quotient : remainder;
        end
    end

endmodule

// ==== hdl/complexIntegerUnit.sv ====
/*
 * Top of the complex integer path. Connects the issue queue, the issue
 * stage, two execution lanes and the shared divider with its arbiter.
 */
`timescale 1ns/1ps

module complexIntegerUnit (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        dispatchValid,
    input  complexOpPkg::ComplexOpEntry dispatchOp,
    output logic                        queueFull,
    input  pipelinePkg::FlushRange      recovery,
    output complexOpPkg::ComplexResult  result [pipelinePkg::issueWidth]
);
    import complexOpPkg::*;
    import pipelinePkg::*;

    IssueStageReg selected [issueWidth];
    ComplexOpEntry selectedOp [issueWidth];
    logic issue [issueWidth];
    QueueIndex issuePtr [issueWidth];
    logic flushed [issueWidth];
    ExecStageReg execIn [issueWidth];
    logic divRequest [issueWidth];
    logic divGrant [issueWidth];
    logic divDone [issueWidth];
    logic laneBusy [issueWidth];
    ComplexOpEntry divOperand [issueWidth];
    logic stall;
    logic divStart;
    logic dividerBusy;
    logic dividerDone;
    logic [dataWidth-1:0] dividend;
    logic [dataWidth-1:0] divisor;
    logic [dataWidth-1:0] quotient;
    logic [dataWidth-1:0] remainder;

    // Operand copy per lane, read when that lane wins the divider
    always_ff @(posedge clock) begin
        for (int i = 0; i < issueWidth; i++) begin
            if (execIn[i].valid) begin
                divOperand[i] <= execIn[i].op;
            end
        end
    end

    always_comb begin
        stall = 1'b0;
        dividend = divOperand[0].srcA;
        divisor = divOperand[0].srcB;
        for (int i = 0; i < issueWidth; i++) begin
            stall = stall | laneBusy[i];
            if (divGrant[i]) begin
                dividend = divOperand[i].srcA;
                divisor = divOperand[i].srcB;
            end
        end
    end

    complexIssueQueue u_complexIssueQueue (
        .clock, .reset, .dispatchValid, .dispatchOp, .queueFull, .stall,
        .recovery, .selected, .selectedOp, .issue, .issuePtr, .flushed
    );

    complexIssueStage u_complexIssueStage (
        .clock, .reset, .stall, .recovery, .selected, .selectedOp,
        .issue, .issuePtr, .flushed, .execIn
    );

    for (genvar i = 0; i < issueWidth; i++) begin : gLane
        complexExecLane u_complexExecLane (
            .clock, .reset, .execIn(execIn[i]), .divRequest(divRequest[i]),
            .divGrant(divGrant[i]), .divDone(divDone[i]), .quotient, .remainder,
            .busy(laneBusy[i]), .result(result[i])
        );
    end

    divArbiter u_divArbiter (
        .clock, .reset, .divRequest, .divGrant, .divStart, .dividerBusy,
        .dividerDone, .divDone
    );

    serialDivider u_serialDivider (
        .clock, .reset, .start(divStart), .dividend, .divisor,
        .busy(dividerBusy), .done(dividerDone), .quotient, .remainder
    );

endmodule

// ==== hdl/complexIssueQueue.sv ====
/*
 * Four-entry issue queue for complex ops. Takes dispatched ops, selects up
 * to two ready entries per cycle for the issue stage, and frees entries
 * once the stage reports them issued or flushed.
 */
`timescale 1ns/1ps

module complexIssueQueue (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        dispatchValid,
    input  complexOpPkg::ComplexOpEntry dispatchOp,
    output logic                        queueFull,
    input  logic                        stall,
    input  pipelinePkg::FlushRange      recovery,
    output pipelinePkg::IssueStageReg   selected [pipelinePkg::issueWidth],
    output complexOpPkg::ComplexOpEntry selectedOp [pipelinePkg::issueWidth],
    input  logic                        issue [pipelinePkg::issueWidth],
    input  pipelinePkg::QueueIndex      issuePtr [pipelinePkg::issueWidth],
    input  logic                        flushed [pipelinePkg::issueWidth]
);
    import complexOpPkg::*;
    import pipelinePkg::*;

    ComplexOpEntry opEntry [queueDepth];
    logic entryValid [queueDepth];
    logic entryScheduled [queueDepth];
    logic pick [queueDepth];
    logic inRange [queueDepth];
    logic freeHit [queueDepth];
    logic hasFree;
    QueueIndex dispatchSlot;

    always_comb begin
        int count;
        count = 0;
        hasFree = 1'b0;
        dispatchSlot = '0;
        for (int i = 0; i < issueWidth; i++) begin
            selected[i] = '0;
            // Stage looks up its op by the pointer it holds
            selectedOp[i] = opEntry[issuePtr[i]];
        end
        for (int e = queueDepth - 1; e >= 0; e--) begin
            if (!entryValid[e]) begin
                hasFree = 1'b1;
                dispatchSlot = QueueIndex'(e);
            end
        end
        for (int e = 0; e < queueDepth; e++) begin
            inRange[e] = inFlushRange(recovery, opEntry[e].activeListPtr);
            pick[e] = 1'b0;
            freeHit[e] = 1'b0;
            for (int i = 0; i < issueWidth; i++) begin
                if ((issue[i] || flushed[i]) && issuePtr[i] == QueueIndex'(e)) begin
                    freeHit[e] = 1'b1;
                end
            end
            // Lowest-indexed ready entries win, none while stalled
            if (!stall && entryValid[e] && !entryScheduled[e] && !inRange[e] &&
                count < issueWidth) begin
                selected[count].valid = 1'b1;
                selected[count].queuePtr = QueueIndex'(e);
                pick[e] = 1'b1;
                count++;
            end
        end
        queueFull = !hasFree;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < queueDepth; e++) begin
                entryValid[e] <= 1'b0;
                entryScheduled[e] <= 1'b0;
            end
        end else begin
            for (int e = 0; e < queueDepth; e++) begin
                if (freeHit[e]) begin
                    entryValid[e] <= 1'b0;
                    entryScheduled[e] <= 1'b0;
                end else if (pick[e]) begin
                    entryScheduled[e] <= 1'b1;
                end else if (entryValid[e] && !entryScheduled[e] && inRange[e]) begin
                    entryValid[e] <= 1'b0;
                end
                if (dispatchValid && hasFree && dispatchSlot == QueueIndex'(e)) begin
                    entryValid[e] <= 1'b1;
                    entryScheduled[e] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dispatchValid && hasFree) begin
            opEntry[dispatchSlot] <= dispatchOp;
        end
    end

endmodule

// ==== hdl/complexIssueStage.sv ====
/*
 * Issue stage of the complex path. Holds one pipeline register per lane,
 * keeps it under stall, drops lanes hit by recovery and reports issue or
 * flush back to the queue while forwarding issued ops to the lanes.
 */
`timescale 1ns/1ps

module complexIssueStage (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        stall,
    input  pipelinePkg::FlushRange      recovery,
    input  pipelinePkg::IssueStageReg   selected [pipelinePkg::issueWidth],
    input  complexOpPkg::ComplexOpEntry selectedOp [pipelinePkg::issueWidth],
    output logic                        issue [pipelinePkg::issueWidth],
    output pipelinePkg::QueueIndex      issuePtr [pipelinePkg::issueWidth],
    output logic                        flushed [pipelinePkg::issueWidth],
    output pipelinePkg::ExecStageReg    execIn [pipelinePkg::issueWidth]
);
    import pipelinePkg::*;

    IssueStageReg pipeReg [issueWidth];
    logic flushHit [issueWidth];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < issueWidth; i++) begin
                pipeReg[i] <= '0;
            end
        end else begin
            for (int i = 0; i < issueWidth; i++) begin
                if (!stall) begin
                    pipeReg[i] <= selected[i];
                end else begin
                    // Held lanes still lose their op on a matching recovery
                    pipeReg[i].valid <= pipeReg[i].valid && !flushHit[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < issueWidth; i++) begin
            flushHit[i] = inFlushRange(recovery, selectedOp[i].activeListPtr);

            issue[i] = pipeReg[i].valid && !stall && !flushHit[i];
            issuePtr[i] = pipeReg[i].queuePtr;
            // Frees the queue entry of a selected op that never issues
            flushed[i] = pipeReg[i].valid && flushHit[i];

            execIn[i].valid = issue[i];
            execIn[i].op = selectedOp[i];
        end
    end

endmodule

// ==== hdl/complexOpPkg.sv ====
/*
 * Op-level types for the complex integer path: opcodes, operand width,
 * the dispatched op entry and the lane result. Compiled before pipelinePkg.
 */
package complexOpPkg;

    localparam int dataWidth = 16;
    localparam int opIdWidth = 6;
    // Width of the active-list pointer carried by each op
    localparam int activeListPtrWidth = 4;

    typedef enum logic [1:0] {
        OP_MUL,
        OP_DIV,
        OP_REM
    } ComplexOpcode;

    // One op as it leaves dispatch
    typedef struct packed {
        ComplexOpcode                  opcode;
        logic [dataWidth-1:0]          srcA;
        logic [dataWidth-1:0]          srcB;
        logic [activeListPtrWidth-1:0] activeListPtr;
        logic [opIdWidth-1:0]          opId;
    } ComplexOpEntry;

    typedef struct packed {
        logic                 valid;
        logic [opIdWidth-1:0] opId;
        logic [dataWidth-1:0] value;
    } ComplexResult;

endpackage

// ==== hdl/divArbiter.sv ====
/*
 * Round-robin arbiter for the shared serial divider. Grants one requesting
 * lane while the divider is idle and routes the done pulse to that owner.
 */
`timescale 1ns/1ps

module divArbiter (
    input  logic clock,
    input  logic reset,
    input  logic divRequest [pipelinePkg::issueWidth],
    output logic divGrant [pipelinePkg::issueWidth],
    output logic divStart,
    input  logic dividerBusy,
    input  logic dividerDone,
    output logic divDone [pipelinePkg::issueWidth]
);
    import pipelinePkg::*;

    LaneIndex rrPtr;
    LaneIndex owner;
    LaneIndex grantLane;
    logic ownerValid;

    always_comb begin
        LaneIndex candidate;
        divStart = 1'b0;
        grantLane = rrPtr;
        for (int i = 0; i < issueWidth; i++) begin
            divGrant[i] = 1'b0;
        end
        // Search starts at the favoured lane and wraps
        for (int k = 0; k < issueWidth; k++) begin
            candidate = LaneIndex'((int'(rrPtr) + k) % issueWidth);
            if (!dividerBusy && !ownerValid && !divStart && divRequest[candidate]) begin
                divGrant[candidate] = 1'b1;
                grantLane = candidate;
                divStart = 1'b1;
            end
        end
        for (int i = 0; i < issueWidth; i++) begin
            divDone[i] = dividerDone && ownerValid && owner == LaneIndex'(i);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ownerValid <= 1'b0;
            owner <= '0;
            rrPtr <= '0;
        end else if (divStart) begin
            ownerValid <= 1'b1;
            owner <= grantLane;
        end else if (dividerDone && ownerValid) begin
            ownerValid <= 1'b0;
            rrPtr <= LaneIndex'((int'(owner) + 1) % issueWidth);
        end
    end

endmodule

// ==== hdl/pipelinePkg.sv ====
/*
 * Pipeline-level types: lane count, queue geometry, recovery range and
 * stage registers, plus the selective flush check used by queue and stage.
 */
package pipelinePkg;

    localparam int issueWidth = 2;
    localparam int queueDepth = 4;
    localparam int queueIndexWidth = 2;
    localparam int laneIndexWidth = $clog2(issueWidth);

    typedef logic [complexOpPkg::activeListPtrWidth-1:0] ActiveListPtr;
    typedef logic [queueIndexWidth-1:0] QueueIndex;
    typedef logic [laneIndexWidth-1:0] LaneIndex;

    typedef struct packed {
        logic         toRecovery;
        logic         flushAll;
        ActiveListPtr headPtr;
        ActiveListPtr tailPtr;
    } FlushRange;

    typedef struct packed {
        logic      valid;
        QueueIndex queuePtr;
    } IssueStageReg;

    typedef struct packed {
        logic                       valid;
        complexOpPkg::ComplexOpEntry op;
    } ExecStageReg;

    // Half-open circular range, head up to but not including tail
    function automatic logic inFlushRange(FlushRange range, ActiveListPtr ptr);
        logic hit;
        if (range.headPtr <= range.tailPtr) begin
            hit = (ptr >= range.headPtr) && (ptr < range.tailPtr);
        end else begin
            hit = (ptr >= range.headPtr) || (ptr < range.tailPtr);
        end
        return range.toRecovery && (range.flushAll || hit);
    endfunction

endpackage

// ==== hdl/serialDivider.sv ====
/*
 * Restoring divider producing one quotient bit per cycle. A start pulse
 * latches the operands; done pulses after 16 steps and the quotient and
 * remainder stay put until the next start.
 */
`timescale 1ns/1ps

module serialDivider (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             start,
    input  logic [complexOpPkg::dataWidth-1:0] dividend,
    input  logic [complexOpPkg::dataWidth-1:0] divisor,
    output logic                             busy,
    output logic                             done,
    output logic [complexOpPkg::dataWidth-1:0] quotient,
    output logic [complexOpPkg::dataWidth-1:0] remainder
);
    import complexOpPkg::*;

    logic [dataWidth-1:0] remReg;
    logic [dataWidth-1:0] quoReg;
    logic [dataWidth-1:0] divisorReg;
    logic [$clog2(dataWidth)-1:0] stepCount;
    logic [dataWidth:0] shiftedRem;
    logic [dataWidth:0] trialRem;

    // One bit of the dividend shifts into the partial remainder
    assign shiftedRem = {remReg, quoReg[dataWidth-1]};
    assign trialRem = shiftedRem - {1'b0, divisorReg};

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            stepCount <= '0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
            stepCount <= '0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                stepCount <= stepCount + 1'b1;
                if (&stepCount) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            remReg <= '0;
            quoReg <= dividend;
            divisorReg <= divisor;
        end else if (busy) begin
            // Negative trial means restore, zero divisor never restores
            if (!trialRem[dataWidth]) begin
                remReg <= trialRem[dataWidth-1:0];
                quoReg <= {quoReg[dataWidth-2:0], 1'b1};
            end else begin
                remReg <= shiftedRem[dataWidth-1:0];
                quoReg <= {quoReg[dataWidth-2:0], 1'b0};
            end
        end
    end

    assign quotient = quoReg;
    assign remainder = remReg;

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it into sim.log and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f vlog.f --top-module complexIntegerUnitTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
exit 0

// ==== vlog.f ====
hdl/complexOpPkg.sv
hdl/pipelinePkg.sv
hdl/complexIssueQueue.sv
hdl/complexIssueStage.sv
hdl/divArbiter.sv
hdl/serialDivider.sv
hdl/complexExecLane.sv
hdl/complexIntegerUnit.sv
bench/complexIntegerUnitTb.sv
